/* conv_array.f */
verilog/conv_pkg.sv
verilog/conv_cfg_regs.sv
verilog/packet_alloc.sv
verilog/lane_fifo.sv
verilog/mac_lane.sv
verilog/psum_arbiter.sv
verilog/conv_array_top.sv
verif/conv_array_asserts.sv
verif/conv_array_tb.sv

/* Bender.yml */
package:
  name: conv_array

sources:
  - verilog/conv_pkg.sv
  - verilog/conv_cfg_regs.sv
  - verilog/packet_alloc.sv
  - verilog/lane_fifo.sv
  - verilog/mac_lane.sv
  - verilog/psum_arbiter.sv
  - verilog/conv_array_top.sv
  - target: test
    files:
      - verif/conv_array_asserts.sv
      - verif/conv_array_tb.sv

/* verif/conv_array_tb.sv */
module conv_array_tb;

    logic                           clk = 1'b0;
    logic                           rst = 1'b1;
    logic                           psel = 1'b0;
    logic                           penable = 1'b0;
    logic                           pwrite = 1'b0;
    logic [3:0]                     paddr = '0;
    logic [31:0]                    pwdata = '0;
    logic [31:0]                    prdata;
    logic                           pready;
    logic                           pslverr;
    logic                           pkt_valid = 1'b0;
    conv_pkg::in_pkt_u              pkt = '0;
    logic                           pkt_ready;
    logic                           res_valid;
    logic                           res_ready = 1'b0;
    logic [conv_pkg::LANE_ID_W-1:0] res_lane;
    logic [conv_pkg::PSUM_W-1:0]    res_psum;

    // ==================================================
    // Reference model state
    // ==================================================
    logic [conv_pkg::VAL_W-1:0]  weights [conv_pkg::MAX_TAPS];
    logic [conv_pkg::VAL_W-1:0]  win [conv_pkg::NUM_LANES][conv_pkg::MAX_TAPS];
    int                          win_cnt [conv_pkg::NUM_LANES] = '{default: 0};
    logic [conv_pkg::PSUM_W-1:0] exp_q [conv_pkg::NUM_LANES][$];
    int                          taps = 0;
    int                          wr_ptr = 0;
    int                          drops = 0;
    int                          stretch = 0;
    logic                        in_ifmap = 1'b0;           // Model of the allocator phase
    logic                        bp_on = 1'b0;
    logic [31:0]                 stim_seed = 32'd77055;
    logic [31:0]                 bp_seed = 32'd77055 ^ 32'h5a5a5a5a;
    logic [31:0]                 rd;                        // Last APB read data
    logic                        err;                       // Last APB pslverr

    conv_array_top conv_array_top_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_step(stim_seed);
        return stim_seed >> 8;                              // Low bits of an LCG are weak
    endfunction

    // Expected window sum is each value times the tap at its position
    function automatic logic [conv_pkg::PSUM_W-1:0] ref_psum(
        input logic [conv_pkg::VAL_W-1:0] w [conv_pkg::MAX_TAPS],
        input int n,
        input logic [conv_pkg::VAL_W-1:0] v [conv_pkg::MAX_TAPS]);
        logic [conv_pkg::PSUM_W-1:0] s;
        s = '0;
        for (int i = 0; i < n; i++)
            s += conv_pkg::PSUM_W'(v[i]) * conv_pkg::PSUM_W'(w[i]);
        return s;
    endfunction

    task automatic die(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_psum(input logic [conv_pkg::PSUM_W-1:0] got, exp, input int lane);
        if (got !== exp)
            die($sformatf("ERR %0t: lane %0d psum 0x%08h, expected 0x%08h",
                          $time, lane, got, exp));
    endtask

    task automatic check_lane(input logic [conv_pkg::LANE_ID_W-1:0] lane, input int pending);
        if (lane >= conv_pkg::NUM_LANES || pending == 0)
            die($sformatf("ERR %0t: result from lane %0d with no pending sum", $time, lane));
    endtask

    task automatic check_reg(input logic [31:0] got, exp, input string what);
        if (got !== exp)
            die($sformatf("ERR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp));
    endtask

    // Runs one APB setup and access pair starting just after a rising edge
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        int t;
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #2 penable = 1'b1;
        t = 0;
        @(negedge clk);
        while (!pready) begin
            t++;
            if (t > 50)
                die("APB transfer never completed");
            @(negedge clk);
        end
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    // Presents one word, waits for acceptance and then updates the model
    task automatic send_word(input conv_pkg::in_pkt_u p);
        int t;
        int l;
        pkt       = p;
        pkt_valid = 1'b1;
        t = 0;
        @(negedge clk);
        while (!pkt_ready) begin
            t++;
            if (t > 3000)
                die("Timeout: an input word was never accepted");
            @(negedge clk);
        end
        l = int'(p.ifm.dest);
        if (!in_ifmap) begin
            weights[wr_ptr] = p.fil.weight;
            wr_ptr   = p.fil.last ? 0 : (wr_ptr + 1) % conv_pkg::MAX_TAPS;
            in_ifmap = p.fil.last;
        end else if (l >= conv_pkg::NUM_LANES) begin
            drops++;
        end else begin
            win[l][win_cnt[l]] = p.ifm.value;
            win_cnt[l]++;
            if (win_cnt[l] == taps) begin
                exp_q[l].push_back(ref_psum(weights, taps, win[l]));
                win_cnt[l] = 0;
            end
        end
        @(posedge clk);
        #2 pkt_valid = 1'b0;
    endtask

    task automatic load_kernel(input int n);
        conv_pkg::in_pkt_u p;
        p = '0;
        for (int i = 0; i < n; i++) begin
            p.fil.weight = conv_pkg::VAL_W'(next_rand());
            p.fil.last   = (i == n - 1);                // Last weight opens the ifmap phase
            send_word(p);
        end
    endtask

    // Random lanes first, then every open window is completed
    task automatic send_data(input int n);
        conv_pkg::in_pkt_u p;
        p = '0;
        for (int i = 0; i < n; i++) begin
            p.ifm.dest  = conv_pkg::LANE_ID_W'(next_rand() % conv_pkg::NUM_LANES);
            p.ifm.value = conv_pkg::VAL_W'(next_rand());
            send_word(p);
        end
        for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
            while (win_cnt[l] != 0) begin
                p.ifm.dest  = conv_pkg::LANE_ID_W'(l);
                p.ifm.value = conv_pkg::VAL_W'(next_rand());
                send_word(p);
            end
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        foreach (exp_q[l]) begin
            while (exp_q[l].size() != 0) begin
                t++;
                if (t > 5000)
                    die($sformatf("Timeout: lane %0d still owes results", l));
                @(posedge clk);
                #2;
            end
        end
    endtask

    // Result ready stays high or is held low in random stretches
    always @(posedge clk) begin
        #2;
        if (!bp_on || stretch == 0) begin
            bp_seed   = lcg_step(bp_seed);
            res_ready = !bp_on || bp_seed[20];
            stretch   = int'(bp_seed[19:16]);
        end else begin
            stretch--;
        end
    end

    // The result monitor samples mid-cycle where the handshake is stable
    always @(negedge clk) begin
        if (!rst && res_valid && res_ready) begin
            check_lane(res_lane, res_lane < conv_pkg::NUM_LANES ? exp_q[res_lane].size() : 0);
            check_psum(res_psum, exp_q[res_lane].pop_front(), res_lane);
        end
    end

    initial begin
        conv_pkg::in_pkt_u p;
        int                open_lane;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        // ==================================================
        // Filter broadcast and ifmap routing
        // ==================================================
        apb_xfer(1'b1, conv_pkg::ADDR_TAPS, 32'd3);
        taps = 3;
        apb_xfer(1'b1, conv_pkg::ADDR_CTRL, 32'h1);
        load_kernel(3);
        apb_xfer(1'b0, conv_pkg::ADDR_STATUS, 32'd0);
        check_reg(rd, 32'd1, "STATUS after kernel load");
        send_data(60);
        wait_drain();

        // Tap clamp, then a reload with a 5 tap kernel
        apb_xfer(1'b1, conv_pkg::ADDR_TAPS, 32'd0);
        apb_xfer(1'b0, conv_pkg::ADDR_TAPS, 32'd0);
        check_reg(rd, 32'(conv_pkg::MAX_TAPS), "TAPS after writing 0");
        apb_xfer(1'b1, conv_pkg::ADDR_TAPS, 32'd5);
        taps = 5;
        apb_xfer(1'b1, conv_pkg::ADDR_CTRL, 32'h3);
        in_ifmap = 1'b0;
        apb_xfer(1'b0, conv_pkg::ADDR_STATUS, 32'd0);
        check_reg(rd, 32'd0, "STATUS after reload");
        load_kernel(5);
        send_data(50);
        wait_drain();

        // Destinations 14 and 15 are counted, never routed
        p = '0;
        for (int i = 0; i < 6; i++) begin
            p.ifm.dest  = conv_pkg::LANE_ID_W'(14 + i % 2);
            p.ifm.value = conv_pkg::VAL_W'(next_rand());
            send_word(p);
        end
        apb_xfer(1'b0, conv_pkg::ADDR_DROPS, 32'd0);
        check_reg(rd, 32'(drops), "DROPS");

        // ==================================================
        // Back-pressure on the result stream
        // ==================================================
        bp_on = 1'b1;
        send_data(150);
        wait_drain();
        bp_on = 1'b0;

        // Disabled input holds a word off, then an unmapped access
        apb_xfer(1'b1, conv_pkg::ADDR_CTRL, 32'h0);
        pkt       = p;
        pkt_valid = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (pkt_ready)
                die("pkt_ready went high while the input was disabled");
        end
        @(posedge clk);
        #2;
        apb_xfer(1'b1, conv_pkg::ADDR_CTRL, 32'h1);
        send_word(p);
        apb_xfer(1'b0, conv_pkg::ADDR_DROPS, 32'd0);
        check_reg(rd, 32'(drops), "DROPS after enable");
        apb_xfer(1'b0, 4'h2, 32'd0);
        if (!err)
            die("An unmapped APB address gave no pslverr");

        wait_drain();
        open_lane = -1;
        foreach (exp_q[l])
            if (exp_q[l].size() != 0 || win_cnt[l] != 0)
                open_lane = l;
        if (open_lane >= 0) begin
            die($sformatf("Lane %0d ended with work outstanding", open_lane));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* verif/conv_array_asserts.sv */
module conv_array_asserts (
    input logic                             clk,
    input logic                             rst,
    input logic                             enable,
    input logic                             pkt_ready,
    input logic [conv_pkg::NUM_LANES-1:0]   lane_push,
    input logic [conv_pkg::NUM_LANES-1:0]   lane_full,
    input logic                             res_valid,
    input logic                             res_ready,
    input logic [conv_pkg::LANE_ID_W-1:0]   res_lane,
    input logic [conv_pkg::PSUM_W-1:0]      res_psum
);

    // The allocator only pushes a lane whose FIFO has room
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        (lane_push & lane_full) == '0) else $error("Push into a full lane FIFO");

    no_ready_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !enable |-> !pkt_ready) else $error("pkt_ready high with enable low");

    // A stalled result stays in place until it is taken
    res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_lane) && $stable(res_psum))
        else $error("Result changed while stalled");

endmodule

bind conv_array_top conv_array_asserts conv_array_asserts_i (.*);

/* verilog/conv_array_top.sv */
module conv_array_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [3:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          pkt_valid,
    input  logic [conv_pkg::PKT_W-1:0]    pkt,
    output logic                          pkt_ready,
    output logic                          res_valid,
    output logic [conv_pkg::LANE_ID_W-1:0] res_lane,
    output logic [conv_pkg::PSUM_W-1:0]   res_psum,
    input  logic                          res_ready
);

    logic                                                  enable;
    logic [conv_pkg::TAP_W-1:0]                            tap_count;
    logic                                                  reload;
    logic                                                  phase;
    logic [conv_pkg::DROP_W-1:0]                           drop_count;
    logic [conv_pkg::NUM_LANES-1:0]                        lane_full;
    logic [conv_pkg::NUM_LANES-1:0]                        lane_push;
    logic [conv_pkg::LANE_W-1:0]                           lane_word;
    logic [conv_pkg::NUM_LANES-1:0]                        fifo_valid;
    logic [conv_pkg::NUM_LANES-1:0][conv_pkg::LANE_W-1:0]  fifo_word;
    logic [conv_pkg::NUM_LANES-1:0]                        fifo_ready;
    logic [conv_pkg::NUM_LANES-1:0]                        psum_valid;
    logic [conv_pkg::NUM_LANES-1:0][conv_pkg::PSUM_W-1:0]  psum;
    logic [conv_pkg::NUM_LANES-1:0]                        psum_ready;

    conv_cfg_regs conv_cfg_regs_i (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .phase, .drop_count,
        .enable, .tap_count, .reload
    );

    packet_alloc packet_alloc_i (
        .clk, .rst,
        .enable, .reload,
        .pkt_valid, .pkt, .pkt_ready,
        .lane_full, .lane_push, .lane_word,
        .phase, .drop_count
    );

    // ==================================================
    // One FIFO and MAC pair per lane
    // ==================================================
    for (genvar g = 0; g < conv_pkg::NUM_LANES; g++) begin : g_lane
        lane_fifo #(.DEPTH(conv_pkg::FIFO_DEPTH)) lane_fifo_i (
            .clk, .rst,
            .push       (lane_push[g]),
            .push_word  (lane_word),               // Shared by every lane
            .full       (lane_full[g]),
            .fifo_valid (fifo_valid[g]),
            .fifo_word  (fifo_word[g]),
            .fifo_ready (fifo_ready[g])
        );

        mac_lane mac_lane_i (
            .clk, .rst,
            .tap_count,
            .fifo_valid (fifo_valid[g]),
            .fifo_word  (fifo_word[g]),
            .fifo_ready (fifo_ready[g]),
            .psum_valid (psum_valid[g]),
            .psum       (psum[g]),
            .psum_ready (psum_ready[g])
        );
    end

    psum_arbiter psum_arbiter_i (
        .clk, .rst,
        .psum_valid, .psum, .psum_ready,
        .res_valid, .res_lane, .res_psum, .res_ready
    );

endmodule

/* verilog/psum_arbiter.sv */
module psum_arbiter (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [conv_pkg::NUM_LANES-1:0]                         psum_valid,
    input  logic [conv_pkg::NUM_LANES-1:0][conv_pkg::PSUM_W-1:0]   psum,
    output logic [conv_pkg::NUM_LANES-1:0]                         psum_ready,
    output logic                                                   res_valid,
    output logic [conv_pkg::LANE_ID_W-1:0]                         res_lane,
    output logic [conv_pkg::PSUM_W-1:0]                            res_psum,
    input  logic                                                   res_ready
);

    logic [conv_pkg::LANE_ID_W-1:0] ptr;          // Highest priority lane
    logic [conv_pkg::LANE_ID_W-1:0] grant;
    logic                           found;
    logic                           load;

    // Rotating search that starts at ptr
    always_comb begin
        int cand;
        found = 1'b0;
        grant = '0;
        cand  = 0;
        for (int i = 0; i < conv_pkg::NUM_LANES; i++) begin
            cand = int'(ptr) + i;
            if (cand >= conv_pkg::NUM_LANES)
                cand = cand - conv_pkg::NUM_LANES;
            if (!found && psum_valid[cand]) begin
                found = 1'b1;
                grant = conv_pkg::LANE_ID_W'(cand);
            end
        end
    end

    assign load = found & (~res_valid | res_ready); // Output empty or draining now

    always_comb begin
        psum_ready = '0;
        if (load)
            psum_ready[grant] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_lane <= grant;
            res_psum <= psum[grant];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            ptr       <= '0;
        end else if (load) begin
            res_valid <= 1'b1;
            if (grant == conv_pkg::LANE_ID_W'(conv_pkg::NUM_LANES - 1))
                ptr <= '0;
            else
                ptr <= grant + 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

endmodule

/* verilog/mac_lane.sv */
module mac_lane (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [conv_pkg::TAP_W-1:0]    tap_count,
    input  logic                          fifo_valid,
    input  logic [conv_pkg::LANE_W-1:0]   fifo_word,
    output logic                          fifo_ready,
    output logic                          psum_valid,
    output logic [conv_pkg::PSUM_W-1:0]   psum,
    input  logic                          psum_ready
);

    logic [conv_pkg::VAL_W-1:0]     taps [conv_pkg::MAX_TAPS];
    logic [conv_pkg::TAP_IDX_W-1:0] wr_ptr;
    logic [conv_pkg::TAP_W-1:0]     rd_idx;      // Position inside the current window
    logic [conv_pkg::PSUM_W-1:0]    acc;
    logic [conv_pkg::PSUM_W-1:0]    sum;
    logic                           take;
    logic                           is_weight;
    logic                           win_done;

    // Stall the FIFO only while a finished sum is stuck
    assign fifo_ready = ~psum_valid | psum_ready;
    assign take       = fifo_valid & fifo_ready;
    assign is_weight  = fifo_word[conv_pkg::LANE_KIND_BIT];

    assign sum = acc + conv_pkg::PSUM_W'(fifo_word[conv_pkg::VAL_W-1:0])
                     * conv_pkg::PSUM_W'(taps[rd_idx[conv_pkg::TAP_IDX_W-1:0]]);
    assign win_done = (rd_idx + 1'b1) == tap_count;

    always_ff @(posedge clk) begin
        if (take && is_weight)
            taps[wr_ptr] <= fifo_word[conv_pkg::VAL_W-1:0];
        if (take && !is_weight && win_done)
            psum <= sum;
    end

    // ==================================================
    // Window control
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_idx     <= '0;
            acc        <= '0;
            psum_valid <= 1'b0;
        end else begin
            if (take && is_weight) begin
                if (fifo_word[conv_pkg::LANE_LAST_BIT])
                    wr_ptr <= '0;                 // Next kernel starts at tap 0
                else
                    wr_ptr <= wr_ptr + 1'b1;      // Wraps past MAX_TAPS
            end

            if (take && !is_weight) begin
                if (win_done) begin
                    acc    <= '0;
                    rd_idx <= '0;
                end else begin
                    acc    <= sum;
                    rd_idx <= rd_idx + 1'b1;
                end
            end

            if (take && !is_weight && win_done)
                psum_valid <= 1'b1;
            else if (psum_ready)
                psum_valid <= 1'b0;
        end
    end

endmodule

/* verilog/lane_fifo.sv */
module lane_fifo #(
    parameter int DEPTH = conv_pkg::FIFO_DEPTH    // Power of two, at least 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic [conv_pkg::LANE_W-1:0]   push_word,
    output logic                          full,
    output logic                          fifo_valid,
    output logic [conv_pkg::LANE_W-1:0]   fifo_word,
    input  logic                          fifo_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [conv_pkg::LANE_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic                        pop;

    assign pop        = fifo_valid & fifo_ready;
    assign fifo_valid = count != '0;
    assign fifo_word  = mem[rd_ptr];              // Head comes straight from storage
    assign full       = count == CNT_W'(DEPTH);

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_word;
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/packet_alloc.sv */
module packet_alloc (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,
    input  logic                             reload,
    input  logic                             pkt_valid,
    input  conv_pkg::in_pkt_u                pkt,
    output logic                             pkt_ready,
    input  logic [conv_pkg::NUM_LANES-1:0]   lane_full,
    output logic [conv_pkg::NUM_LANES-1:0]   lane_push,
    output logic [conv_pkg::LANE_W-1:0]      lane_word,
    output logic                             phase,      // 0 filter, 1 ifmap
    output logic [conv_pkg::DROP_W-1:0]      drop_count
);

    logic in_range;
    logic accept;

    assign in_range = pkt.ifm.dest < conv_pkg::NUM_LANES;

    // Filter words need room everywhere, ifmap words only at their lane
    always_comb begin
        if (!enable)
            pkt_ready = 1'b0;
        else if (!phase)
            pkt_ready = ~(|lane_full);
        else if (!in_range)
            pkt_ready = 1'b1;                     // Dropped, so nothing to wait for
        else
            pkt_ready = ~lane_full[pkt.ifm.dest];
    end

    assign accept = pkt_valid & pkt_ready;

    always_comb begin
        lane_push = '0;
        if (accept) begin
            if (!phase)
                lane_push = '1;                   // Broadcast the weight
            else if (in_range)
                lane_push = {{(conv_pkg::NUM_LANES-1){1'b0}}, 1'b1} << pkt.ifm.dest;
        end
    end

    // Weight and feature value sit in the same low bits of the input word
    always_comb begin
        lane_word                      = '0;
        lane_word[conv_pkg::VAL_W-1:0] = pkt.ifm.value;
        if (!phase) begin
            lane_word[conv_pkg::LANE_KIND_BIT] = 1'b1;
            lane_word[conv_pkg::LANE_LAST_BIT] = pkt.fil.last;
        end
    end

    // ==================================================
    // Phase and drop tracking
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= 1'b0;
        end else if (reload) begin
            phase <= 1'b0;
        end else if (accept && !phase && pkt.fil.last) begin
            phase <= 1'b1;                        // Last weight opens the ifmap phase
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            drop_count <= '0;
        else if (accept && phase && !in_range && drop_count != '1)
            drop_count <= drop_count + 1'b1;      // Saturates at all ones
    end

endmodule

/* verilog/conv_cfg_regs.sv */
module conv_cfg_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [3:0]                   paddr,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic                         phase,
    input  logic [conv_pkg::DROP_W-1:0]  drop_count,
    output logic                         enable,
    output logic [conv_pkg::TAP_W-1:0]   tap_count,
    output logic                         reload
);

    logic access;
    logic wr_en;
    logic mapped;

    assign access = psel & penable;               // APB access phase
    assign wr_en  = access & pwrite;

    always_comb begin
        case (paddr)
            conv_pkg::ADDR_CTRL,
            conv_pkg::ADDR_TAPS,
            conv_pkg::ADDR_STATUS,
            conv_pkg::ADDR_DROPS: mapped = 1'b1;
            default:              mapped = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                        // No wait states
    assign pslverr = access & ~mapped;

    // ==================================================
    // Control and tap registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b0;
            tap_count <= conv_pkg::TAP_W'(conv_pkg::MAX_TAPS);
            reload    <= 1'b0;
        end else begin
            reload <= 1'b0;                       // Only ever high for one cycle
            if (wr_en && paddr == conv_pkg::ADDR_CTRL) begin
                enable <= pwdata[conv_pkg::CTRL_EN_BIT];
                reload <= pwdata[conv_pkg::CTRL_RELOAD_BIT];
            end
            if (wr_en && paddr == conv_pkg::ADDR_TAPS) begin
                // Zero and oversized counts fall back to the full kernel
                if (pwdata == 32'd0 || pwdata > 32'(conv_pkg::MAX_TAPS))
                    tap_count <= conv_pkg::TAP_W'(conv_pkg::MAX_TAPS);
                else
                    tap_count <= pwdata[conv_pkg::TAP_W-1:0];
            end
        end
    end

    // Read mux; the reload bit always reads back as 0
    always_comb begin
        prdata = 32'd0;
        case (paddr)
            conv_pkg::ADDR_CTRL:   prdata[conv_pkg::CTRL_EN_BIT] = enable;
            conv_pkg::ADDR_TAPS:   prdata[conv_pkg::TAP_W-1:0] = tap_count;
            conv_pkg::ADDR_STATUS: prdata[0] = phase;
            conv_pkg::ADDR_DROPS:  prdata[conv_pkg::DROP_W-1:0] = drop_count;
            default:               prdata = 32'd0;
        endcase
    end

endmodule

/* verilog/conv_pkg.sv */
package conv_pkg;

    // ==================================================
    // Array geometry
    // ==================================================
    localparam int NUM_LANES = 14;
    localparam int LANE_ID_W = 4;                 // Also the destination field of an ifmap word

    localparam int VAL_W  = 14;                   // Weight or feature value
    localparam int PKT_W  = 18;                   // One input stream word
    localparam int LANE_W = 16;                   // Word stored in a lane FIFO
    localparam int PSUM_W = 32;

    // Lane word layout is {kind, last, value}
    localparam int LANE_KIND_BIT = 15;            // 1 marks a weight, 0 marks data
    localparam int LANE_LAST_BIT = 14;

    localparam int MAX_TAPS  = 8;
    localparam int TAP_W     = 4;                 // Wide enough to hold MAX_TAPS itself
    localparam int TAP_IDX_W = $clog2(MAX_TAPS);

    localparam int FIFO_DEPTH = 4;
    localparam int DROP_W     = 16;

    // ==================================================
    // Register map
    // ==================================================
    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_TAPS   = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;
    localparam logic [3:0] ADDR_DROPS  = 4'hC;

    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_RELOAD_BIT = 1;

    // The same input word means different things in each phase
    typedef union packed {
        struct packed {
            logic                           last;
            logic [PKT_W-VAL_W-2:0]         spare;
            logic [VAL_W-1:0]               weight;
        } fil;
        struct packed {
            logic [LANE_ID_W-1:0]           dest;
            logic [VAL_W-1:0]               value;
        } ifm;
    } in_pkt_u;

endpackage
